/* verilog/cube_pkg.sv */
package cube_pkg;

    // one sticker holds a colour index 0..5
    localparam int sticker_w = 3;

    localparam int num_faces = 6;
    localparam int num_stickers = 54;

    // stickers 0..47 take part in turns, 48..53 are the centres
    localparam int num_moving = 48;

    typedef logic [sticker_w-1:0] sticker_t;

    // sticker i sits at bits 3i+2 down to 3i
    typedef logic [sticker_w*num_stickers-1:0] cube_state_t;

    localparam int move_w = 4;

    typedef logic [move_w-1:0] move_t;

    // even codes turn clockwise, the next odd code is the inverse
    localparam move_t mv_r = 4'd2;
    localparam move_t mv_ri = 4'd3;
    localparam move_t mv_u = 4'd4;
    localparam move_t mv_ui = 4'd5;
    localparam move_t mv_f = 4'd6;
    localparam move_t mv_fi = 4'd7;
    localparam move_t mv_l = 4'd8;
    localparam move_t mv_li = 4'd9;
    localparam move_t mv_b = 4'd10;
    localparam move_t mv_bi = 4'd11;
    localparam move_t mv_d = 4'd12;
    localparam move_t mv_di = 4'd13;

endpackage

/* verilog/cube_apb_pkg.sv */
package cube_apb_pkg;

    localparam int apb_addr_w = 12;
    localparam int apb_data_w = 32;

    typedef logic [apb_addr_w-1:0] apb_addr_t;
    typedef logic [apb_data_w-1:0] apb_data_t;

    // every register takes one 32-bit word
    localparam apb_addr_t reg_stride = 12'h004;

    localparam apb_addr_t addr_ctrl = 12'h000;
    localparam apb_addr_t addr_status = 12'h004;
    localparam apb_addr_t addr_len = 12'h008;
    localparam apb_addr_t addr_sticker_base = 12'h100;
    localparam apb_addr_t addr_move_base = 12'h200;

    // control, write-only
    localparam int ctrl_start = 0;

    // status, read-only
    localparam int stat_busy = 0;
    localparam int stat_done = 1;

    // width of the length field
    localparam int len_w = 6;

endpackage

/* verilog/cube_turn.sv */
`timescale 1ns/100ps

module cube_turn (
    input  cube_pkg::move_t       move,
    input  cube_pkg::cube_state_t cube_in,
    output cube_pkg::cube_state_t cube_out
);
    import cube_pkg::*;

    localparam int num_cycles = 5;
    localparam int cyc_len = 4;

    // per face, in order R U F L B D: two corner cycles and one edge cycle
    // off the face, then the face corners and the face edges
    // a clockwise turn carries sticker cycles[f][c][j] to cycles[f][c][j+1]
    localparam int cycles [num_faces][num_cycles][cyc_len] = '{
        '{
            '{10,  2, 18, 22},
            '{11,  3, 19, 23},
            '{32, 27, 42, 47},
            '{13, 12, 15, 14},
            '{37, 36, 39, 38}
        },
        '{
            '{13,  8,  7, 18},
            '{12, 11,  6, 17},
            '{36, 35, 30, 43},
            '{ 1,  0,  3,  2},
            '{26, 25, 24, 27}
        },
        '{
            '{ 1, 13, 23,  5},
            '{ 2, 14, 20,  6},
            '{29, 26, 37, 46},
            '{ 8, 11, 10,  9},
            '{34, 35, 32, 33}
        },
        '{
            '{16,  0,  8, 20},
            '{17,  1,  9, 21},
            '{25, 34, 45, 40},
            '{ 4,  7,  6,  5},
            '{28, 31, 30, 29}
        },
        '{
            '{12,  0,  4, 22},
            '{15,  3,  7, 21},
            '{39, 24, 31, 44},
            '{19, 18, 17, 16},
            '{41, 42, 43, 40}
        },
        '{
            '{ 4,  9, 14, 19},
            '{ 5, 10, 15, 16},
            '{28, 33, 38, 41},
            '{21, 20, 23, 22},
            '{45, 46, 47, 44}
        }
    };

    logic       valid;
    logic       inverse;
    logic [2:0] face;
    sticker_t   st_in [num_moving];
    sticker_t   st_out [num_moving];

    always_comb begin
        valid = 1'b1;
        face  = 3'd0;
        case (move)
            mv_r, mv_ri: face = 3'd0;
            mv_u, mv_ui: face = 3'd1;
            mv_f, mv_fi: face = 3'd2;
            mv_l, mv_li: face = 3'd3;
            mv_b, mv_bi: face = 3'd4;
            mv_d, mv_di: face = 3'd5;
            default: valid = 1'b0;
        endcase
    end

    // odd codes run the cycles backwards
    assign inverse = move[0];

    for (genvar i = 0; i < num_moving; i++) begin : g_unpack
        assign st_in[i] = cube_in[sticker_w*i +: sticker_w];
        assign cube_out[sticker_w*i +: sticker_w] = st_out[i];
    end

    always_comb begin
        for (int i = 0; i < num_moving; i++) begin
            st_out[i] = st_in[i];
        end
        for (int f = 0; f < num_faces; f++) begin
            if (valid && face == 3'(f)) begin
                for (int c = 0; c < num_cycles; c++) begin
                    for (int j = 0; j < cyc_len; j++) begin
                        if (inverse) begin
                            st_out[cycles[f][c][j]] = st_in[cycles[f][c][(j + 1) % cyc_len]];
                        end else begin
                            st_out[cycles[f][c][(j + 1) % cyc_len]] = st_in[cycles[f][c][j]];
                        end
                    end
                end
            end
        end
    end

    // centres never move
    assign cube_out[$bits(cube_state_t)-1:sticker_w*num_moving] =
        cube_in[$bits(cube_state_t)-1:sticker_w*num_moving];

endmodule

/* verilog/cube_move_seq.sv */
`timescale 1ns/100ps

module cube_move_seq #(
    parameter  int MAX_MOVES = 50,
    localparam int idx_w     = $clog2(MAX_MOVES + 1)
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  cube_pkg::cube_state_t cube_in,
    input  logic [idx_w-1:0]      move_len,
    input  cube_pkg::move_t       move_code,
    output logic                  busy,
    output logic                  done,
    output logic [idx_w-1:0]      move_idx,
    output cube_pkg::cube_state_t cube_out
);
    import cube_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_turning,
        st_finish
    } seq_state_t;

    seq_state_t  state;
    cube_state_t work;
    cube_state_t turned;
    logic        step;

    cube_turn u_turn (
        .move     (move_code),
        .cube_in  (work),
        .cube_out (turned)
    );

    // one quarter turn per cycle until move_idx reaches the length
    assign step = (state == st_turning) && (move_idx != move_len);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= st_idle;
            move_idx <= '0;
        end else if (start) begin
            state    <= st_turning;
            move_idx <= '0;
        end else begin
            case (state)
                st_turning: begin
                    if (step) begin
                        move_idx <= move_idx + 1'b1;
                    end else begin
                        state <= st_finish;
                    end
                end
                st_finish: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            work <= cube_in;
        end else if (step) begin
            work <= turned;
        end
    end

    assign busy     = (state != st_idle);
    assign done     = (state == st_finish);
    assign cube_out = work;

    // length register is write-locked while busy, so the bound holds
    a_idx_bound: assert property (@(posedge clock) disable iff (!arst_n)
        busy |-> move_idx <= move_len);

    // the sequencer is idle right after write-back
    a_done_pulse: assert property (@(posedge clock) disable iff (!arst_n)
        done |=> !done && !busy);

endmodule

/* verilog/cube_regs.sv */
`timescale 1ns/100ps

module cube_regs #(
    parameter  int MAX_MOVES = 50,
    localparam int idx_w     = $clog2(MAX_MOVES + 1)
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  cube_apb_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  cube_apb_pkg::apb_data_t pwdata,
    output cube_apb_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    busy,
    input  logic                    done,
    input  logic [idx_w-1:0]        move_idx,
    input  cube_pkg::cube_state_t   cube_out,
    output logic                    start,
    output cube_pkg::cube_state_t   cube_in,
    output logic [idx_w-1:0]        move_len,
    output cube_pkg::move_t         move_code
);
    import cube_pkg::*;
    import cube_apb_pkg::*;

    localparam int st_idx_w = $clog2(num_stickers);

    sticker_t            stickers [num_stickers];
    move_t               moves [MAX_MOVES];
    logic [idx_w-1:0]    len_q;
    logic                done_q;

    logic                access;
    logic                wr_ok;
    apb_addr_t           sticker_off;
    apb_addr_t           move_off;
    logic [st_idx_w-1:0] sticker_sel;
    logic [idx_w-1:0]    move_sel;
    logic                hit_ctrl;
    logic                hit_status;
    logic                hit_len;
    logic                hit_sticker;
    logic                hit_move;
    logic                hit_guarded;
    logic                hit_any;
    logic [len_w-1:0]    len_wr;
    logic [idx_w-1:0]    len_clip;

    assign access = psel && penable;

    // address decode, arrays are word aligned from their base
    assign sticker_off = paddr - addr_sticker_base;
    assign move_off    = paddr - addr_move_base;
    assign sticker_sel = st_idx_w'(sticker_off / reg_stride);
    assign move_sel    = idx_w'(move_off / reg_stride);

    assign hit_ctrl    = (paddr == addr_ctrl);
    assign hit_status  = (paddr == addr_status);
    assign hit_len     = (paddr == addr_len);
    assign hit_sticker = (sticker_off < apb_addr_t'(num_stickers) * reg_stride)
                         && ((sticker_off % reg_stride) == '0);
    assign hit_move    = (move_off < apb_addr_t'(MAX_MOVES) * reg_stride)
                         && ((move_off % reg_stride) == '0);

    // everything but status is locked while a job runs
    assign hit_guarded = hit_ctrl || hit_len || hit_sticker || hit_move;
    assign hit_any     = hit_guarded || hit_status;

    assign pready  = 1'b1;
    assign pslverr = access && (!hit_any || (pwrite && busy && hit_guarded));
    assign wr_ok   = access && pwrite && hit_guarded && !busy;
    assign start   = wr_ok && hit_ctrl && pwdata[ctrl_start];

    assign len_wr   = pwdata[len_w-1:0];
    assign len_clip = (len_wr > len_w'(MAX_MOVES)) ? idx_w'(MAX_MOVES) : idx_w'(len_wr);

    always_comb begin
        prdata = '0;
        if (hit_status) begin
            prdata[stat_busy] = busy;
            prdata[stat_done] = done_q;
        end else if (hit_len) begin
            prdata = apb_data_t'(len_q);
        end else if (hit_sticker) begin
            prdata = apb_data_t'(stickers[sticker_sel]);
        end else if (hit_move) begin
            prdata = apb_data_t'(moves[move_sel]);
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_stickers; i++) begin
                stickers[i] <= '0;
            end
            for (int j = 0; j < MAX_MOVES; j++) begin
                moves[j] <= '0;
            end
            len_q  <= '0;
            done_q <= 1'b0;
        end else if (done) begin
            // turned cube comes back into the sticker registers
            for (int i = 0; i < num_stickers; i++) begin
                stickers[i] <= cube_out[sticker_w*i +: sticker_w];
            end
            done_q <= 1'b1;
        end else if (wr_ok) begin
            if (hit_sticker) begin
                stickers[sticker_sel] <= pwdata[sticker_w-1:0];
            end
            if (hit_move) begin
                moves[move_sel] <= pwdata[move_w-1:0];
            end
            if (hit_len) begin
                len_q <= len_clip;
            end
            if (start) begin
                done_q <= 1'b0;
            end
        end
    end

    for (genvar i = 0; i < num_stickers; i++) begin : g_cube_in
        assign cube_in[sticker_w*i +: sticker_w] = stickers[i];
    end

    assign move_len = len_q;

    // the sequencer looks one past the last move when it stops
    assign move_code = (move_idx < idx_w'(MAX_MOVES)) ? moves[move_idx] : '0;

    // an access phase always follows the setup phase of its transfer
    a_pslverr_access: assert property (@(posedge clock) disable iff (!arst_n)
        pslverr |-> psel && penable && $past(psel && !penable));

    // an accepted start is always picked up by the sequencer
    a_start_idle: assert property (@(posedge clock) disable iff (!arst_n)
        start |-> !busy ##1 busy);

endmodule

/* verilog/cube_top.sv */
`timescale 1ns/100ps

module cube_top #(
    parameter  int MAX_MOVES = 50,
    localparam int idx_w     = $clog2(MAX_MOVES + 1)
) (
    input  logic                    clock,
    input  logic                    arst_n,
    input  cube_apb_pkg::apb_addr_t paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  cube_apb_pkg::apb_data_t pwdata,
    output cube_apb_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import cube_pkg::*;

    logic             start;
    logic             busy;
    logic             done;
    cube_state_t      cube_in;
    cube_state_t      cube_out;
    logic [idx_w-1:0] move_len;
    logic [idx_w-1:0] move_idx;
    move_t            move_code;

    cube_regs #(
        .MAX_MOVES (MAX_MOVES)
    ) u_regs (
        .clock     (clock),
        .arst_n    (arst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .busy      (busy),
        .done      (done),
        .move_idx  (move_idx),
        .cube_out  (cube_out),
        .start     (start),
        .cube_in   (cube_in),
        .move_len  (move_len),
        .move_code (move_code)
    );

    cube_move_seq #(
        .MAX_MOVES (MAX_MOVES)
    ) u_seq (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .cube_in   (cube_in),
        .move_len  (move_len),
        .move_code (move_code),
        .busy      (busy),
        .done      (done),
        .move_idx  (move_idx),
        .cube_out  (cube_out)
    );

endmodule

/* verif/cube_tb.sv */
`timescale 1ns/100ps

module cube_tb;
    import cube_pkg::*;
    import cube_apb_pkg::*;

    localparam int max_moves = 50;
    localparam int clk_period = 40;
    localparam int drive_delay = 2;
    localparam int reset_cycles = 5;

    // a run writes and reads back the cube, writes the moves and polls status,
    // two cycles per access, plus the job itself
    localparam int run_accesses = 2 * num_stickers + 2 * max_moves + 8;
    localparam int num_runs = 13;
    localparam int timeout_cycles = 2 * num_runs * (2 * run_accesses + max_moves + 2);

    logic      clock;
    logic      arst_n;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    logic [31:0] rng_state;
    int          cycles;
    int          tests;
    int          checks;
    int          errors;
    int          test_errors;
    string       test_name;

    // model of the cube that software loads, and what comes back
    sticker_t init_st [num_stickers];
    sticker_t dut_st [num_stickers];
    move_t    move_list [max_moves];

    cube_top #(
        .MAX_MOVES (max_moves)
    ) u_dut (
        .clock   (clock),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("timeout: DUT did not finish within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    function automatic apb_addr_t sticker_addr(input int i);
        return addr_sticker_base + apb_addr_t'(4 * i);
    endfunction

    function automatic apb_addr_t move_addr(input int j);
        return addr_move_base + apb_addr_t'(4 * j);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("ERR %s %s: expected 0x%0h, actual 0x%0h", test_name, name,
                     expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done: %0d errors", name, test_errors);
        tests++;
        test_errors = 0;
    endtask

    // setup phase, then access phase sampled mid-cycle
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t data,
                              output apb_data_t rdata, output logic err);
        paddr   = addr;
        pwrite  = write;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #drive_delay;
        penable = 1'b1;
        #(clk_period / 2);
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        #drive_delay;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             output apb_data_t rdata, output logic err);
        apb_access(1'b1, addr, data, rdata, err);
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata, output logic err);
        apb_access(1'b0, addr, '0, rdata, err);
    endtask

    task automatic random_cube();
        logic [31:0] r;
        for (int i = 0; i < num_stickers; i++) begin
            next_random(r);
            init_st[i] = sticker_t'(r % 6);
        end
    endtask

    // k random turns followed by the same turns reversed and inverted
    task automatic inverse_pairs(input int k);
        logic [31:0] r;
        for (int j = 0; j < k; j++) begin
            next_random(r);
            move_list[j] = move_t'(2 + r % 12);
            move_list[2 * k - 1 - j] = move_list[j] ^ 4'd1;
        end
    endtask

    task automatic load_cube();
        apb_data_t rd;
        logic      err;
        for (int i = 0; i < num_stickers; i++) begin
            apb_write(sticker_addr(i), apb_data_t'(init_st[i]), rd, err);
            check("sticker load pslverr", 0, 32'(err));
        end
    endtask

    task automatic load_moves(input int count);
        apb_data_t rd;
        logic      err;
        for (int j = 0; j < count; j++) begin
            apb_write(move_addr(j), apb_data_t'(move_list[j]), rd, err);
            check("move load pslverr", 0, 32'(err));
        end
    endtask

    task automatic start_job(input int len);
        apb_data_t rd;
        logic      err;
        apb_write(addr_len, apb_data_t'(len), rd, err);
        check("length write pslverr", 0, 32'(err));
        apb_write(addr_ctrl, 1, rd, err);
        check("start pslverr", 0, 32'(err));
    endtask

    task automatic wait_done();
        apb_data_t rd;
        logic      err;
        rd = '0;
        while (!(rd[stat_done] && !rd[stat_busy])) begin
            apb_read(addr_status, rd, err);
        end
    endtask

    task automatic read_cube();
        apb_data_t rd;
        logic      err;
        for (int i = 0; i < num_stickers; i++) begin
            apb_read(sticker_addr(i), rd, err);
            dut_st[i] = rd[2:0];
        end
    endtask

    task automatic run_sequence(input int len);
        load_cube();
        load_moves(len);
        start_job(len);
        wait_done();
        read_cube();
    endtask

    task automatic compare_with_init(input string name);
        for (int i = 0; i < num_stickers; i++) begin
            check($sformatf("%s sticker %0d", name, i), 32'(init_st[i]), 32'(dut_st[i]));
        end
    endtask

    task automatic compare_histogram(input string name);
        int hist_exp [8];
        int hist_got [8];
        for (int c = 0; c < 8; c++) begin
            hist_exp[c] = 0;
            hist_got[c] = 0;
        end
        for (int i = 0; i < num_stickers; i++) begin
            hist_exp[init_st[i]]++;
            hist_got[dut_st[i]]++;
        end
        for (int c = 0; c < 8; c++) begin
            check($sformatf("%s colour %0d count", name, c), hist_exp[c], hist_got[c]);
        end
        for (int i = num_moving; i < num_stickers; i++) begin
            check($sformatf("%s centre %0d", name, i), 32'(init_st[i]), 32'(dut_st[i]));
        end
    endtask

    task automatic readback_registers();
        sticker_t    exp_st [num_stickers];
        move_t       exp_mv [max_moves];
        apb_addr_t   bad_addr [5];
        apb_data_t   rd;
        logic [31:0] r;
        logic        err;
        int          len_field;
        test_name = "register readback";
        apb_read(addr_status, rd, err);
        check("status after reset", 0, rd);
        apb_read(addr_len, rd, err);
        check("length after reset", 0, rd);
        check("pready", 1, 32'(pready));
        for (int i = 0; i < num_stickers; i++) begin
            next_random(r);
            exp_st[i] = r[2:0];
            apb_write(sticker_addr(i), r, rd, err);
            check("sticker write pslverr", 0, 32'(err));
        end
        for (int i = 0; i < num_stickers; i++) begin
            apb_read(sticker_addr(i), rd, err);
            check($sformatf("sticker %0d readback", i), 32'(exp_st[i]), rd);
        end
        for (int j = 0; j < max_moves; j++) begin
            next_random(r);
            exp_mv[j] = r[3:0];
            apb_write(move_addr(j), r, rd, err);
            check("move write pslverr", 0, 32'(err));
        end
        for (int j = 0; j < max_moves; j++) begin
            apb_read(move_addr(j), rd, err);
            check($sformatf("move %0d readback", j), 32'(exp_mv[j]), rd);
        end
        next_random(r);
        len_field = int'(r[5:0]);
        apb_write(addr_len, r, rd, err);
        apb_read(addr_len, rd, err);
        check("length readback", (len_field > max_moves) ? max_moves : len_field, rd);
        apb_write(addr_len, 63, rd, err);
        apb_read(addr_len, rd, err);
        check("length clipped", max_moves, rd);
        apb_read(addr_ctrl, rd, err);
        check("control reads zero", 0, rd);
        bad_addr = '{12'h00c, 12'h102, move_addr(max_moves), 12'h300, 12'hffc};
        for (int k = 0; k < 5; k++) begin
            apb_read(bad_addr[k], rd, err);
            check("unmapped read data", 0, rd);
            check("unmapped read pslverr", 1, 32'(err));
            apb_write(bad_addr[k], 32'hffff_ffff, rd, err);
            check("unmapped write pslverr", 1, 32'(err));
        end
        apb_read(sticker_addr(0), rd, err);
        check("sticker after unmapped write", 32'(exp_st[0]), rd);
        finish_test("register readback");
    endtask

    task automatic inverse_sequence();
        apb_data_t   rd;
        logic [31:0] r;
        logic        err;
        int          k;
        test_name = "inverse sequence";
        random_cube();
        next_random(r);
        k = 1 + r % (max_moves / 2);
        inverse_pairs(k);
        run_sequence(2 * k);
        compare_with_init("inverse sequence");
        apb_read(addr_status, rd, err);
        check("inverse sequence status", 32'h2, rd);
        finish_test("inverse sequence");
    endtask

    task automatic fourfold_and_noop();
        logic [31:0] r;
        move_t       code;
        test_name = "fourfold turn and no-op codes";
        for (int f = 0; f < num_faces; f++) begin
            random_cube();
            next_random(r);
            code = move_t'(2 + 2 * f + r % 2);
            for (int j = 0; j < 4; j++) begin
                move_list[j] = code;
            end
            run_sequence(4);
            compare_with_init($sformatf("fourfold face %0d", f));
        end
        // codes 0, 1, 14 and 15 only
        for (int j = 0; j < max_moves; j++) begin
            next_random(r);
            move_list[j] = r[1] ? (4'd14 + {3'd0, r[0]}) : {3'd0, r[0]};
        end
        run_sequence(max_moves);
        compare_with_init("no-op codes");
        // valid turns in memory that a zero-length run must leave unused
        for (int j = 0; j < max_moves; j++) begin
            next_random(r);
            move_list[j] = move_t'(2 + r % 12);
        end
        load_moves(max_moves);
        run_sequence(0);
        compare_with_init("zero length");
        finish_test("fourfold turn and no-op codes");
    endtask

    task automatic colour_conservation();
        logic [31:0] r;
        int          diffs;
        test_name = "conservation";
        for (int i = 0; i < num_stickers; i++) begin
            init_st[i] = sticker_t'(i % 6);
        end
        for (int j = 0; j < max_moves; j++) begin
            next_random(r);
            move_list[j] = move_t'(2 + r % 12);
        end
        run_sequence(max_moves);
        compare_histogram("random sequence");
        for (int j = 0; j < max_moves; j++) begin
            next_random(r);
            move_list[j] = r[0] ? 4'd15 : 4'd0;
        end
        next_random(r);
        move_list[r % max_moves] = move_t'(2 + (r >> 8) % 12);
        run_sequence(max_moves);
        compare_histogram("single move");
        diffs = 0;
        for (int i = 0; i < num_stickers; i++) begin
            if (init_st[i] != dut_st[i]) begin
                diffs++;
            end
        end
        check("single move changes cube", 1, (diffs > 0) ? 1 : 0);
        finish_test("conservation");
    endtask

    task automatic busy_protection();
        apb_data_t rd;
        logic      err;
        int        k;
        test_name = "busy protection";
        random_cube();
        k = max_moves / 2;
        inverse_pairs(k);
        load_cube();
        load_moves(2 * k);
        start_job(2 * k);
        apb_read(addr_status, rd, err);
        check("status while busy", 1, rd);
        apb_write(sticker_addr(0), apb_data_t'(init_st[0] ^ 3'd7), rd, err);
        check("sticker write while busy", 1, 32'(err));
        apb_write(addr_len, 1, rd, err);
        check("length write while busy", 1, 32'(err));
        apb_write(addr_ctrl, 1, rd, err);
        check("start while busy", 1, 32'(err));
        // the job is still running, so the sticker register must be untouched
        apb_read(sticker_addr(0), rd, err);
        check("sticker kept while busy", 32'(init_st[0]), rd);
        wait_done();
        read_cube();
        compare_with_init("busy protection");
        apb_read(addr_len, rd, err);
        check("length kept while busy", 2 * k, rd);
        finish_test("busy protection");
    endtask

    initial begin
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        arst_n      = 1'b1;
        rng_state   = 32'd54;
        cycles      = 0;
        tests       = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        #drive_delay;
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #drive_delay;
        arst_n = 1'b1;
        @(posedge clock);
        #drive_delay;
        readback_registers();
        inverse_sequence();
        fourfold_and_noop();
        colour_conservation();
        busy_protection();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* filelist.f */
verilog/cube_pkg.sv
verilog/cube_apb_pkg.sv
verilog/cube_turn.sv
verilog/cube_move_seq.sv
verilog/cube_regs.sv
verilog/cube_top.sv
verif/cube_tb.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module cube_tb -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --assert verilog/cube_pkg.sv verilog/cube_apb_pkg.sv \
		verilog/cube_turn.sv verilog/cube_move_seq.sv verilog/cube_regs.sv \
		verilog/cube_top.sv --top-module cube_top
	verilator --lint-only --timing --assert -f filelist.f --top-module cube_tb

clean:
	rm -rf obj_dir
